/* hdl/sdmac_pkg.sv */
// SCSI DMA controller shared definitions
// Register offsets, control and status bit positions, decoder strobes

package sdmac_pkg;

  // Register offsets within the chip window
  localparam logic [7:0] OFF_WTC     = 8'h04;
  localparam logic [7:0] OFF_CNTR    = 8'h08;
  localparam logic [7:0] OFF_ACR     = 8'h0C;
  localparam logic [7:0] OFF_ST_DMA  = 8'h10;
  localparam logic [7:0] OFF_FLUSH   = 8'h14;
  localparam logic [7:0] OFF_CLR_INT = 8'h18;
  localparam logic [7:0] OFF_ISTR    = 8'h1C;
  localparam logic [7:0] OFF_SP_DMA  = 8'h3C;

  // Everything from here up goes to the SCSI chip
  localparam logic [7:0] OFF_WD_BASE = 8'h40;

  // CNTR bit positions
  localparam int unsigned CNTR_DMADIR = 1;
  localparam int unsigned CNTR_INTEN  = 2;

  // Implemented CNTR bits, the rest read back as 0
  localparam logic [31:0] CNTR_MASK = (32'd1 << CNTR_DMADIR) | (32'd1 << CNTR_INTEN);

  // ISTR bit positions
  localparam int unsigned ISTR_INT_P   = 4;
  localparam int unsigned ISTR_SCSI    = 3;
  localparam int unsigned ISTR_DMA_ACT = 1;

  // One-cycle strobes from the address decoder
  typedef struct packed {
    logic wtc_rd;
    logic cntr_rd;
    logic cntr_wr;
    logic acr_wr;
    logic istr_rd;
    // Action strobes, either direction
    logic st_dma;
    logic sp_dma;
    logic clr_int;
    logic flush_req;
  } reg_strobe_t;

endpackage

/* hdl/sdmac_bus_if.sv */
// Latched CPU access as seen inside the register port
// Driven by the input side, read by decode, registers and output side

`timescale 1ns/1ns

interface sdmac_bus_if #(
  parameter int ADDR_W = 8,
  parameter int DATA_W = 32
);

  logic [ADDR_W-1:0] addr;    // Latched offset
  logic [DATA_W-1:0] wdata;   // Latched write data
  logic              rw;      // High for a read
  logic              cycle;   // Access in progress
  logic              access;  // First cycle of the access

  // Input side owns everything
  modport src (output addr, wdata, rw, cycle, access);

  // Address decode
  modport dec (input addr, rw, cycle, access);

  // Register block only needs the write data
  modport regs (input wdata);

  // Output side, acknowledge and data enable
  modport out (input rw, cycle, access);

endinterface

/* hdl/cpu_bus_sync.sv */
// CPU bus input side
// Finds the start of an access, latches address, data and direction

`timescale 1ns/1ns

module cpu_bus_sync #(
  parameter int ADDR_W = 8,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cs_n,
  input  logic              as_n,
  input  logic              rw,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] data_in,
  sdmac_bus_if.src          bus
);

  logic sel;
  logic sel_q;
  logic start;
  logic cycle_q;
  logic access_q;

  // Chip is selected while both strobes are low
  assign sel = ~cs_n & ~as_n;

  // New access only on the first selected sample
  // as_n has to go high before sel_q drops again
  assign start = sel & ~sel_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_q    <= 1'b0;
      cycle_q  <= 1'b0;
      access_q <= 1'b0;
    end else begin
      sel_q    <= sel;
      access_q <= start;
      // Held until the CPU drops its address strobe
      if (start) begin
        cycle_q <= 1'b1;
      end else if (as_n) begin
        cycle_q <= 1'b0;
      end
    end
  end

  // Access payload, only loaded at the start edge
  always_ff @(posedge clk) begin
    if (start) begin
      bus.addr  <= addr;
      bus.wdata <= data_in;
      bus.rw    <= rw;
    end
  end

  assign bus.cycle  = cycle_q;
  assign bus.access = access_q;

  // Start pulse must sit inside the access window
  a_access_in_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    bus.access |-> bus.cycle
  ) else $error("access pulse outside of bus cycle");

endmodule

/* hdl/addr_decoder.sv */
// Register address decoder
// Turns the latched offset into register and action strobes, SCSI select

`timescale 1ns/1ns

module addr_decoder #(
  parameter int ADDR_W = 8
) (
  sdmac_bus_if.dec          bus,
  output sdmac_pkg::reg_strobe_t strb,
  output logic              local_hit,
  output logic              wd_sel
);

  logic h_04;
  logic h_08;
  logic h_0c;
  logic h_10;
  logic h_14;
  logic h_18;
  logic h_1c;
  logic h_3c;
  logic rd;
  logic wr;

  // Offset matches, only during the access pulse
  assign h_04 = bus.access & (bus.addr == ADDR_W'(sdmac_pkg::OFF_WTC));
  assign h_08 = bus.access & (bus.addr == ADDR_W'(sdmac_pkg::OFF_CNTR));
  assign h_0c = bus.access & (bus.addr == ADDR_W'(sdmac_pkg::OFF_ACR));
  assign h_10 = bus.access & (bus.addr == ADDR_W'(sdmac_pkg::OFF_ST_DMA));
  assign h_14 = bus.access & (bus.addr == ADDR_W'(sdmac_pkg::OFF_FLUSH));
  assign h_18 = bus.access & (bus.addr == ADDR_W'(sdmac_pkg::OFF_CLR_INT));
  assign h_1c = bus.access & (bus.addr == ADDR_W'(sdmac_pkg::OFF_ISTR));
  assign h_3c = bus.access & (bus.addr == ADDR_W'(sdmac_pkg::OFF_SP_DMA));

  // rw high is a read
  assign rd = bus.rw;
  assign wr = ~bus.rw;

  // Register strobes
  assign strb.wtc_rd  = h_04 & rd;
  assign strb.cntr_rd = h_08 & rd;
  assign strb.cntr_wr = h_08 & wr;
  assign strb.acr_wr  = h_0c & wr;
  assign strb.istr_rd = h_1c & rd;

  // Action strobes fire for reads and writes alike
  assign strb.st_dma    = h_10;
  assign strb.sp_dma    = h_3c;
  assign strb.clr_int   = h_18;
  // Direction check happens in the register block
  assign strb.flush_req = h_14;

  // Any of our own offsets gets an acknowledge
  assign local_hit = h_04 | h_08 | h_0c | h_10 | h_14 | h_18 | h_1c | h_3c;

  // SCSI chip window, held for the whole cycle
  assign wd_sel = bus.cycle & (bus.addr >= ADDR_W'(sdmac_pkg::OFF_WD_BASE));

  // Offsets are distinct so at most one strobe may be active
  always_comb begin
    a_strb_onehot: assert ($onehot0(strb))
      else $error("more than one decoder strobe active");
  end

endmodule

/* hdl/sdmac_regs.sv */
// Register block of the DMA controller
// CNTR, ACR, DMA run flag, interrupt latch and read data select

`timescale 1ns/1ns

module sdmac_regs #(
  parameter int DATA_W = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  sdmac_bus_if.regs              bus,
  input  sdmac_pkg::reg_strobe_t strb,
  input  logic                   scsi_int,
  input  logic [DATA_W-1:0]      xfer_count,
  output logic [DATA_W-1:0]      rdata,
  output logic                   dma_run,
  output logic                   dma_dir,
  output logic                   flush,
  output logic                   int_n,
  output logic [DATA_W-1:0]      acr
);

  localparam logic [DATA_W-1:0] MASK = DATA_W'(sdmac_pkg::CNTR_MASK);

  logic [DATA_W-1:0] cntr_q;
  logic [DATA_W-1:0] acr_q;
  logic [DATA_W-1:0] istr;
  logic              run_q;
  logic              int_p_q;
  logic              flush_q;

  // Control and address registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cntr_q <= '0;
      acr_q  <= '0;
    end else begin
      // Unimplemented bits never stored
      if (strb.cntr_wr) begin
        cntr_q <= bus.wdata & MASK;
      end
      // ACR just kept for the DMA engine
      if (strb.acr_wr) begin
        acr_q <= bus.wdata;
      end
    end
  end

  // DMA run state, pending interrupt and flush pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q   <= 1'b0;
      int_p_q <= 1'b0;
      flush_q <= 1'b0;
    end else begin
      if (strb.st_dma) begin
        run_q <= 1'b1;
      end else if (strb.sp_dma) begin
        run_q <= 1'b0;
      end
      // Set wins over clear
      if (scsi_int) begin
        int_p_q <= 1'b1;
      end else if (strb.clr_int) begin
        int_p_q <= 1'b0;
      end
      // Flush only has meaning in the write-to-memory direction
      flush_q <= strb.flush_req & cntr_q[sdmac_pkg::CNTR_DMADIR];
    end
  end

  // Interrupt status as the CPU sees it
  always_comb begin
    istr = '0;
    istr[sdmac_pkg::ISTR_INT_P]   = int_p_q;
    istr[sdmac_pkg::ISTR_SCSI]    = scsi_int;  // live level
    istr[sdmac_pkg::ISTR_DMA_ACT] = run_q;
  end

  // Read data mux, strobes are one-hot
  always_comb begin
    if (strb.cntr_rd) begin
      rdata = cntr_q;
    end else if (strb.istr_rd) begin
      rdata = istr;
    end else if (strb.wtc_rd) begin
      rdata = xfer_count;
    end else begin
      rdata = '0;
    end
  end

  assign dma_run = run_q;
  assign dma_dir = cntr_q[sdmac_pkg::CNTR_DMADIR];
  assign flush   = flush_q;
  assign acr     = acr_q;

  // Interrupt line gated by the enable bit
  assign int_n = ~(int_p_q & cntr_q[sdmac_pkg::CNTR_INTEN]);

  // Start and stop come from different offsets
  a_start_stop_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(strb.st_dma && strb.sp_dma)
  ) else $error("start and stop DMA in the same cycle");

endmodule

/* hdl/cpu_data_out.sv */
// CPU bus output side
// Read data register, data enable and the held acknowledge

`timescale 1ns/1ns

module cpu_data_out #(
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  sdmac_bus_if.out          bus,
  input  logic              local_hit,
  input  logic [DATA_W-1:0] rdata,
  output logic [DATA_W-1:0] data_out,
  output logic              data_oe,
  output logic              dsack_n
);

  logic              ack_q;
  logic              oe_q;
  logic [DATA_W-1:0] data_q;

  // Ack armed one cycle after the access pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      oe_q  <= 1'b0;
    end else if (bus.access && local_hit) begin
      ack_q <= 1'b1;
      oe_q  <= bus.rw;
    end else if (!bus.cycle) begin
      ack_q <= 1'b0;
      oe_q  <= 1'b0;
    end
  end

  // Read data captured with the ack
  always_ff @(posedge clk) begin
    if (bus.access && local_hit) begin
      data_q <= rdata;
    end
  end

  // Released as soon as the cycle ends
  assign dsack_n  = ~(ack_q & bus.cycle);
  assign data_oe  = oe_q & bus.cycle;
  assign data_out = data_q;

  // Bus only driven while acknowledging
  a_oe_with_ack: assert property (
    @(posedge clk) disable iff (!rst_n)
    data_oe |-> !dsack_n
  ) else $error("data enabled without dsack");

endmodule

/* hdl/sdmac_top.sv */
// SCSI DMA controller CPU register port, top level
// Input side, decoder, registers and output side

`timescale 1ns/1ns

module sdmac_top #(
  parameter int ADDR_W = 8,
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cs_n,
  input  logic              as_n,
  input  logic              rw,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] data_in,
  input  logic              scsi_int,
  input  logic [DATA_W-1:0] xfer_count,
  output logic [DATA_W-1:0] data_out,
  output logic              data_oe,
  output logic              dsack_n,
  output logic              wd_sel,
  output logic              int_n,
  output logic              dma_run,
  output logic              dma_dir,
  output logic              flush,
  output logic [DATA_W-1:0] acr
);

  sdmac_pkg::reg_strobe_t strb;
  logic                   local_hit;
  logic [DATA_W-1:0]      rdata;

  // Latched access shared by all blocks
  sdmac_bus_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) bus_i ();

  cpu_bus_sync #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) sync_i (
    .clk, .rst_n, .cs_n, .as_n, .rw, .addr, .data_in,
    .bus (bus_i.src)
  );

  addr_decoder #(.ADDR_W(ADDR_W)) dec_i (
    .bus (bus_i.dec),
    .strb, .local_hit, .wd_sel
  );

  sdmac_regs #(.DATA_W(DATA_W)) regs_i (
    .clk, .rst_n,
    .bus (bus_i.regs),
    .strb, .scsi_int, .xfer_count,
    .rdata, .dma_run, .dma_dir, .flush, .int_n, .acr
  );

  cpu_data_out #(.DATA_W(DATA_W)) out_i (
    .clk, .rst_n,
    .bus (bus_i.out),
    .local_hit, .rdata,
    .data_out, .data_oe, .dsack_n
  );

endmodule

/* test/tb_sdmac.sv */
// Testbench for the SCSI DMA controller CPU register port
// Directed bus accesses against registers, action strobes and the SCSI window

`timescale 1ns/1ns

module tb_sdmac;

  localparam int ADDR_W            = 8;
  localparam int DATA_W            = 32;
  localparam int CLK_PERIOD        = 10;
  localparam int ACK_WAIT_CYCLES   = 20;
  // Watchdog budget covers about 40 accesses of at most 50 cycles each
  localparam int NUM_ACCESSES      = 40;
  localparam int MAX_ACCESS_CYCLES = 50;
  localparam int WATCHDOG_NS       = NUM_ACCESSES * MAX_ACCESS_CYCLES * CLK_PERIOD;

  // Expected register layouts built from the bit positions
  localparam logic [31:0] CNTR_BITS = (32'd1 << sdmac_pkg::CNTR_DMADIR) |
                                      (32'd1 << sdmac_pkg::CNTR_INTEN);
  localparam logic [31:0] DIR_BIT   = 32'd1 << sdmac_pkg::CNTR_DMADIR;
  localparam logic [31:0] INTEN_BIT = 32'd1 << sdmac_pkg::CNTR_INTEN;
  localparam logic [31:0] PEND_BIT  = 32'd1 << sdmac_pkg::ISTR_INT_P;
  localparam logic [31:0] SCSI_BIT  = 32'd1 << sdmac_pkg::ISTR_SCSI;
  localparam logic [31:0] ACT_BIT   = 32'd1 << sdmac_pkg::ISTR_DMA_ACT;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              cs_n;
  logic              as_n;
  logic              rw;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] data_in;
  logic              scsi_int;
  logic [DATA_W-1:0] xfer_count;
  logic [DATA_W-1:0] data_out;
  logic              data_oe;
  logic              dsack_n;
  logic              wd_sel;
  logic              int_n;
  logic              dma_run;
  logic              dma_dir;
  logic              flush;
  logic [DATA_W-1:0] acr;

  integer            seed = 62152;
  int                flush_count = 0;

  sdmac_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) dut_i (
    .clk, .rst_n, .cs_n, .as_n, .rw, .addr, .data_in, .scsi_int, .xfer_count,
    .data_out, .data_oe, .dsack_n, .wd_sel, .int_n, .dma_run, .dma_dir,
    .flush, .acr
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Flush pulses counted mid-cycle where the level is settled
  always @(negedge clk) begin
    if (flush) begin
      flush_count <= flush_count + 1;
    end
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      stop_with_failure($sformatf("** Error [%s] expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      stop_with_failure($sformatf("** Error [%s] expected %b actual %b", name, exp, act));
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // One register access held until dsack_n and then released
  task automatic run_access(input logic is_read, input logic [7:0] offset,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    cs_n    = 1'b0;
    as_n    = 1'b0;
    rw      = is_read;
    addr    = offset;
    data_in = wdata;
    wait_cycles(1);
    while (dsack_n && waited < ACK_WAIT_CYCLES) begin
      wait_cycles(1);
      waited++;
    end
    assert (!dsack_n) else begin
      stop_with_failure($sformatf("no acknowledge for access at offset 0x%02h", offset));
    end
    // Output enable only for reads
    check_bit($sformatf("data_oe during access 0x%02h", offset), is_read, data_oe);
    rdata = data_out;
    as_n  = 1'b1;
    cs_n  = 1'b1;
    rw    = 1'b1;
    wait_cycles(1);
    assert (dsack_n && !data_oe) else begin
      stop_with_failure($sformatf("bus not released after access at offset 0x%02h", offset));
    end
  endtask

  task automatic bus_write(input logic [7:0] offset, input logic [31:0] wdata);
    logic [31:0] unused;
    run_access(1'b0, offset, wdata, unused);
  endtask

  task automatic bus_read(input logic [7:0] offset, output logic [31:0] rdata);
    run_access(1'b1, offset, 32'h0, rdata);
  endtask

  task automatic test_reset_state();
    logic [31:0] rd;
    check_bit("reset dsack_n", 1'b1, dsack_n);
    check_bit("reset int_n", 1'b1, int_n);
    check_bit("reset dma_run", 1'b0, dma_run);
    check_bit("reset flush", 1'b0, flush);
    check_bit("reset wd_sel", 1'b0, wd_sel);
    check_bit("reset data_oe", 1'b0, data_oe);
    bus_read(sdmac_pkg::OFF_CNTR, rd);
    check_word("reset cntr", 32'h0, rd);
  endtask

  task automatic test_registers();
    logic [31:0] val;
    logic [31:0] rd;
    val = $random(seed);
    bus_write(sdmac_pkg::OFF_CNTR, val);
    bus_read(sdmac_pkg::OFF_CNTR, rd);
    check_word("cntr readback", val & CNTR_BITS, rd);
    check_bit("cntr dma_dir", val[sdmac_pkg::CNTR_DMADIR], dma_dir);
    // Both values of the direction bit
    bus_write(sdmac_pkg::OFF_CNTR, ~val);
    check_bit("cntr dma_dir inverted", ~val[sdmac_pkg::CNTR_DMADIR], dma_dir);
    val = $random(seed);
    bus_write(sdmac_pkg::OFF_ACR, val);
    check_word("acr output", val, acr);
    xfer_count = $random(seed);
    bus_read(sdmac_pkg::OFF_WTC, rd);
    check_word("wtc read", xfer_count, rd);
    bus_write(sdmac_pkg::OFF_CNTR, 32'h0);
  endtask

  task automatic test_dma_run();
    logic [31:0] rd;
    bus_write(sdmac_pkg::OFF_ST_DMA, 32'h0);
    check_bit("start dma", 1'b1, dma_run);
    bus_read(sdmac_pkg::OFF_ISTR, rd);
    check_word("istr dma active", ACT_BIT, rd);
    bus_write(sdmac_pkg::OFF_SP_DMA, 32'h0);
    check_bit("stop dma", 1'b0, dma_run);
  endtask

  task automatic test_flush();
    int start;
    bus_write(sdmac_pkg::OFF_CNTR, DIR_BIT);
    start = flush_count;
    bus_write(sdmac_pkg::OFF_FLUSH, 32'h0);
    wait_cycles(3);
    check_word("flush with dir set", 32'd1, 32'(flush_count - start));
    bus_write(sdmac_pkg::OFF_CNTR, 32'h0);
    start = flush_count;
    bus_write(sdmac_pkg::OFF_FLUSH, 32'h0);
    wait_cycles(3);
    check_word("flush with dir clear", 32'd0, 32'(flush_count - start));
  endtask

  task automatic test_interrupt();
    logic [31:0] rd;
    bus_write(sdmac_pkg::OFF_CNTR, INTEN_BIT);
    scsi_int = 1'b1;
    wait_cycles(2);
    check_bit("int_n enabled", 1'b0, int_n);
    bus_read(sdmac_pkg::OFF_ISTR, rd);
    check_word("istr pending and scsi", PEND_BIT | SCSI_BIT, rd);
    // Pending stays latched after the source drops
    scsi_int = 1'b0;
    wait_cycles(2);
    check_bit("int_n held", 1'b0, int_n);
    bus_write(sdmac_pkg::OFF_CLR_INT, 32'h0);
    check_bit("int_n cleared", 1'b1, int_n);
    bus_read(sdmac_pkg::OFF_ISTR, rd);
    check_word("istr cleared", 32'h0, rd);
    // Status stays visible with the enable off
    bus_write(sdmac_pkg::OFF_CNTR, 32'h0);
    scsi_int = 1'b1;
    wait_cycles(2);
    check_bit("int_n masked", 1'b1, int_n);
    scsi_int = 1'b0;
    wait_cycles(1);
    check_bit("int_n masked after drop", 1'b1, int_n);
    bus_read(sdmac_pkg::OFF_ISTR, rd);
    check_word("istr masked pending", PEND_BIT, rd);
    bus_write(sdmac_pkg::OFF_CLR_INT, 32'h0);
  endtask

  task automatic scsi_access(input logic [7:0] offset);
    cs_n = 1'b0;
    as_n = 1'b0;
    rw   = 1'b1;
    addr = offset;
    repeat (10) begin
      wait_cycles(1);
      check_bit($sformatf("wd_sel at 0x%02h", offset), 1'b1, wd_sel);
      assert (dsack_n) else begin
        stop_with_failure($sformatf("acknowledge driven for SCSI offset 0x%02h", offset));
      end
    end
    as_n = 1'b1;
    cs_n = 1'b1;
    wait_cycles(1);
    check_bit($sformatf("wd_sel released 0x%02h", offset), 1'b0, wd_sel);
  endtask

  task automatic test_scsi_window();
    logic [31:0] rd;
    scsi_access(8'h40);
    scsi_access(8'h7C);
    bus_read(sdmac_pkg::OFF_CNTR, rd);
    check_word("register after scsi", 32'h0, rd);
  endtask

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("watchdog expired before the tests completed");
  end

  initial begin
    rst_n      = 1'b0;
    cs_n       = 1'b1;
    as_n       = 1'b1;
    rw         = 1'b1;
    addr       = '0;
    data_in    = '0;
    scsi_int   = 1'b0;
    xfer_count = '0;
    wait_cycles(16);
    rst_n = 1'b1;
    wait_cycles(2);
    test_reset_state();
    test_registers();
    test_dma_run();
    test_flush();
    test_interrupt();
    test_scsi_window();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* all.f */
hdl/sdmac_pkg.sv
hdl/sdmac_bus_if.sv
hdl/cpu_bus_sync.sv
hdl/addr_decoder.sv
hdl/sdmac_regs.sv
hdl/cpu_data_out.sv
hdl/sdmac_top.sv
test/tb_sdmac.sv

/* run.sh */
#!/bin/sh
# Build and run the register port testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_sdmac \
  -f all.f \
  -o sim_tb_sdmac

# Exit status of the simulation decides pass or fail
./obj_dir/sim_tb_sdmac
